/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module simdCoreTb -f simdCore.f \
    > sim.log 2>&1 && ./obj_dir/VsimdCoreTb >> sim.log 2>&1
grep -qx "Testbench passed" sim.log && echo "PASS" || { cat sim.log; echo "FAIL"; exit 1; }

/* simdCore.f */
+incdir+source
source/simdPkg.sv
source/simdDecoder.sv
source/laneAlu.sv
source/registerBanks.sv
source/memPort.sv
source/simdCore.sv
testbench/simdCoreTb.sv

/* source/laneAlu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module laneAlu import simdPkg::*; (
    input wire [`SIMD_DATA_WIDTH-1:0] a,
    input wire [`SIMD_DATA_WIDTH-1:0] b,
    input wire aluOpT op,
    input wire laneModeT mode,
    output logic [`SIMD_DATA_WIDTH-1:0] result
);
    localparam int octW = `SIMD_DATA_WIDTH / 2;
    localparam int quadW = `SIMD_DATA_WIDTH / 4;

    logic [`SIMD_DATA_WIDTH-1:0] sum;
    logic [`SIMD_DATA_WIDTH-1:0] diff;
    logic [`SIMD_DATA_WIDTH-1:0] prod;

    // each lane wraps on its own, no carry or product bits leak upward
    always_comb
    begin
        sum = a + b;
        diff = a - b;
        prod = a * b;                          // low half of the full product
        if (mode == laneO)
        begin
            for (int i = 0; i < 2; i++)
            begin
                sum[i*octW +: octW] = a[i*octW +: octW] + b[i*octW +: octW];
                diff[i*octW +: octW] = a[i*octW +: octW] - b[i*octW +: octW];
                prod[i*octW +: octW] = a[i*octW +: octW] * b[i*octW +: octW];
            end
        end
        else if (mode == laneQ)
        begin
            for (int i = 0; i < 4; i++)
            begin
                sum[i*quadW +: quadW] = a[i*quadW +: quadW] + b[i*quadW +: quadW];
                diff[i*quadW +: quadW] = a[i*quadW +: quadW] - b[i*quadW +: quadW];
                prod[i*quadW +: quadW] = a[i*quadW +: quadW] * b[i*quadW +: quadW];
            end
        end
    end

    always_comb
    begin
        case (op)
            aluAdd: result = sum;
            aluSub: result = diff;
            aluMul: result = prod;
            aluAnd: result = a & b;
            aluOr: result = a | b;
            aluNot: result = ~a;               // lane independent anyway
            aluSet: result = b;                // b is the replicated immediate
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/memPort.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module memPort import simdPkg::*; (
    input wire clk,
    input wire rst,
    input wire start,
    input wire memReqT request,
    input wire ack,
    input wire [`SIMD_DATA_WIDTH-1:0] rdata,
    output logic req,
    output memReqT memReq,
    output logic [`SIMD_DATA_WIDTH-1:0] loadData,
    output logic finished
);
    typedef enum logic [1:0] {mpIdle, mpWaitAck, mpRelease, mpDone} portStateT;

    portStateT state;
    logic launch;

    // never raise req over a lingering ack
    assign launch = (state == mpIdle) && start && !ack;
    assign finished = (state == mpDone);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= mpIdle;
            req <= 1'b0;
        end
        else
        begin
            case (state)
                mpIdle:
                begin
                    if (launch)
                    begin
                        req <= 1'b1;
                        state <= mpWaitAck;
                    end
                end
                mpWaitAck:
                begin
                    if (ack)
                    begin
                        req <= 1'b0;
                        state <= mpRelease;
                    end
                end
                mpRelease: if (!ack) state <= mpDone;
                default: state <= mpIdle;      // mpDone, start is ignored here
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (launch)
            memReq <= request;                 // held for the whole req phase
        if (state == mpWaitAck && ack && !memReq.write)
            loadData <= rdata;
    end

endmodule

`default_nettype wire

/* source/registerBanks.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module registerBanks import simdPkg::*; (
    input wire clk,
    input wire rst,
    input wire laneModeT mode,
    input wire regIdxT rdIdxA,
    input wire regIdxT rdIdxB,
    input wire wrEn,
    input wire regIdxT wrIdx,
    input wire [`SIMD_DATA_WIDTH-1:0] wrData,
    output logic [`SIMD_DATA_WIDTH-1:0] rdA,
    output logic [`SIMD_DATA_WIDTH-1:0] rdB
);
    // bank 0 is H, 1 is O, 2 is Q
    logic [`SIMD_DATA_WIDTH-1:0] banks [0:2][0:`SIMD_REG_COUNT-1];
    logic [1:0] bankSel;

    always_comb
    begin
        case (mode)
            laneO: bankSel = 2'd1;
            laneQ: bankSel = 2'd2;
            default: bankSel = 2'd0;           // unused mode code lands on H
        endcase
    end

    assign rdA = banks[bankSel][rdIdxA];
    assign rdB = banks[bankSel][rdIdxB];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int bk = 0; bk < 3; bk++)
            begin
                for (int r = 0; r < `SIMD_REG_COUNT; r++)
                begin
                    banks[bk][r] <= '0;
                end
            end
        end
        else if (wrEn)
        begin
            banks[bankSel][wrIdx] <= wrData;
        end
    end

endmodule

`default_nettype wire

/* source/simdCore.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module simdCore import simdPkg::*; (
    input wire clk,
    input wire rst,
    input wire [`SIMD_INSTR_WIDTH-1:0] instr,
    input wire ack,
    input wire [`SIMD_DATA_WIDTH-1:0] rdata,
    output logic [`SIMD_ADDR_WIDTH-1:0] instrAddr,
    output logic req,
    output memReqT memReq,
    output logic done
);
    coreStateT state;
    logic [`SIMD_ADDR_WIDTH-1:0] pc;
    decodedInstT dec;
    decodedInstT decReg;
    logic [`SIMD_DATA_WIDTH-1:0] rdA;
    logic [`SIMD_DATA_WIDTH-1:0] rdB;
    logic [`SIMD_DATA_WIDTH-1:0] aluB;
    logic [`SIMD_DATA_WIDTH-1:0] aluResult;
    logic [`SIMD_DATA_WIDTH-1:0] resultReg;
    logic [`SIMD_DATA_WIDTH-1:0] loadData;
    logic [`SIMD_DATA_WIDTH-1:0] wbData;
    logic isMem;
    logic memStart;
    logic memFinished;
    logic regWrite;
    memReqT memRequest;

    assign instrAddr = pc;
    assign done = (state == stHalt);

    assign isMem = (decReg.instrClass == classLoad) || (decReg.instrClass == classStore);
    assign memStart = (state == stMemory) && isMem;
    assign aluB = decReg.useImm ? decReg.immValue : rdB;
    assign regWrite = (state == stWriteBack) && decReg.writesReg;
    assign wbData = (decReg.instrClass == classLoad) ? loadData : resultReg;

    // store data comes from R0 through port A
    assign memRequest.addr = decReg.immValue[`SIMD_ADDR_WIDTH-1:0];
    assign memRequest.write = (decReg.instrClass == classStore);
    assign memRequest.wdata = rdA;

    simdDecoder decoder (
        .instr(instr),
        .dec(dec)
    );

    registerBanks banks (
        .clk(clk),
        .rst(rst),
        .mode(decReg.mode),
        .rdIdxA(decReg.srcA),
        .rdIdxB(decReg.srcB),
        .wrEn(regWrite),
        .wrIdx(decReg.dest),
        .wrData(wbData),
        .rdA(rdA),
        .rdB(rdB)
    );

    laneAlu alu (
        .a(rdA),
        .b(aluB),
        .op(decReg.aluOp),
        .mode(decReg.mode),
        .result(aluResult)
    );

    memPort port (
        .clk(clk),
        .rst(rst),
        .start(memStart),
        .request(memRequest),
        .ack(ack),
        .rdata(rdata),
        .req(req),
        .memReq(memReq),
        .loadData(loadData),
        .finished(memFinished)
    );

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= stIdle;
            pc <= '0;
        end
        else
        begin
            case (state)
                stIdle: state <= stFetch;
                stFetch: state <= stDecode;    // rom output settles on pc
                stDecode: state <= (dec.instrClass == classHalt) ? stHalt : stExecute;
                stExecute: state <= stMemory;
                stMemory: if (!isMem || memFinished) state <= stWriteBack;
                stWriteBack:
                begin
                    pc <= pc + 1'b1;
                    state <= stFetch;
                end
                stHalt: state <= stHalt;       // only reset leaves
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == stDecode)
            decReg <= dec;
        if (state == stExecute)
            resultReg <= aluResult;
    end

endmodule

`default_nettype wire

/* source/simdDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module simdDecoder import simdPkg::*; (
    input wire [`SIMD_INSTR_WIDTH-1:0] instr,
    output decodedInstT dec
);
    opcodeT op;
    regIdxT r0;
    regIdxT r2;
    regIdxT r3;
    logic [`SIMD_IMM_WIDTH-1:0] imm;
    logic [`SIMD_DATA_WIDTH-1:0] zeroImm;
    logic [`SIMD_DATA_WIDTH-1:0] repImm;
    laneModeT mode;
    aluOpT aluOp;

    assign op = opcodeT'(instr[`SIMD_INSTR_WIDTH-1 -: `SIMD_OPCODE_WIDTH]);
    assign r0 = instr[11:10];
    assign r2 = instr[3:2];
    assign r3 = instr[1:0];
    assign imm = instr[`SIMD_IMM_WIDTH-1:0];
    assign zeroImm = {{(`SIMD_DATA_WIDTH - `SIMD_IMM_WIDTH){1'b0}}, imm};

    always_comb
    begin
        case (op)
            opAddRegO, opAddImmO, opSubRegO, opSubImmO, opMulRegO, opMulImmO,
            opAndO, opOrO, opNotO, opLoadO, opStoreO, opSetO: mode = laneO;
            opAddRegQ, opAddImmQ, opSubRegQ, opSubImmQ, opMulRegQ, opMulImmQ,
            opAndQ, opOrQ, opNotQ, opLoadQ, opStoreQ, opSetQ: mode = laneQ;
            default: mode = laneH;
        endcase

        case (op)
            opSubRegH, opSubRegO, opSubRegQ, opSubImmH, opSubImmO, opSubImmQ: aluOp = aluSub;
            opMulRegH, opMulRegO, opMulRegQ, opMulImmH, opMulImmO, opMulImmQ: aluOp = aluMul;
            opAndH, opAndO, opAndQ: aluOp = aluAnd;
            opOrH, opOrO, opOrQ: aluOp = aluOr;
            opNotH, opNotO, opNotQ: aluOp = aluNot;
            opSetH, opSetO, opSetQ: aluOp = aluSet;
            default: aluOp = aluAdd;
        endcase
    end

    // immediate copied into every lane
    always_comb
    begin
        case (mode)
            laneO: repImm = {2{imm[7:0]}};
            laneQ: repImm = {4{imm[3:0]}};
            default: repImm = zeroImm;
        endcase
    end

    always_comb
    begin
        dec = '0;
        dec.instrClass = classNop;
        dec.aluOp = aluOp;
        dec.mode = mode;
        dec.srcA = r2;
        dec.srcB = r3;
        dec.dest = r2;
        dec.immValue = repImm;
        case (op)
            opAddRegH, opAddRegO, opAddRegQ, opSubRegH, opSubRegO, opSubRegQ,
            opMulRegH, opMulRegO, opMulRegQ, opAndH, opAndO, opAndQ,
            opOrH, opOrO, opOrQ:
            begin
                dec.instrClass = classAlu;
                dec.writesReg = 1'b1;          // R2 op R3 into R2
            end
            opAddImmH, opAddImmO, opAddImmQ, opSubImmH, opSubImmO, opSubImmQ,
            opMulImmH, opMulImmO, opMulImmQ, opSetH, opSetO, opSetQ:
            begin
                dec.instrClass = classAlu;
                dec.srcA = r0;
                dec.dest = r0;
                dec.useImm = 1'b1;
                dec.writesReg = 1'b1;
            end
            opNotH, opNotO, opNotQ:
            begin
                dec.instrClass = classAlu;
                dec.srcA = r3;
                dec.dest = r3;
                dec.writesReg = 1'b1;
            end
            opLoadH, opLoadO, opLoadQ:
            begin
                dec.instrClass = classLoad;
                dec.dest = r0;
                dec.writesReg = 1'b1;
                dec.immValue = zeroImm;        // plain address
            end
            opStoreH, opStoreO, opStoreQ:
            begin
                dec.instrClass = classStore;
                dec.srcA = r0;
                dec.immValue = zeroImm;
            end
            opHalt: dec.instrClass = classHalt;
            default: dec.instrClass = classNop;
        endcase
    end

endmodule

`default_nettype wire

/* source/simdPkg.sv */
`default_nettype none

package simdPkg;

`include "simdSettings.svh"

    typedef enum logic [`SIMD_OPCODE_WIDTH-1:0] {
        opAddRegH = 6'd0, opAddRegO, opAddRegQ,
        opAddImmH = 6'd3, opAddImmO, opAddImmQ,
        opSubRegH = 6'd6, opSubRegO, opSubRegQ,
        opSubImmH = 6'd9, opSubImmO, opSubImmQ,
        opMulRegH = 6'd12, opMulRegO, opMulRegQ,
        opMulImmH = 6'd15, opMulImmO, opMulImmQ,
        opAndH = 6'd27, opAndO, opAndQ,
        opOrH = 6'd30, opOrO, opOrQ,
        opNotH = 6'd33, opNotO, opNotQ,
        opLoadH = 6'd38, opLoadO, opLoadQ,
        opStoreH = 6'd41, opStoreO, opStoreQ,
        opSetH = 6'd44, opSetO, opSetQ,
        opHalt = 6'd63
    } opcodeT;

    typedef enum logic [1:0] {laneH, laneO, laneQ} laneModeT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluMul, aluAnd, aluOr, aluNot, aluSet} aluOpT;

    typedef enum logic [2:0] {classAlu, classLoad, classStore, classHalt, classNop} instrClassT;

    typedef enum logic [2:0] {
        stIdle, stFetch, stDecode, stExecute, stMemory, stWriteBack, stHalt
    } coreStateT;

    typedef logic [$clog2(`SIMD_REG_COUNT)-1:0] regIdxT;

    typedef struct packed {
        instrClassT instrClass;
        aluOpT aluOp;
        laneModeT mode;
        regIdxT srcA;
        regIdxT srcB;
        regIdxT dest;
        logic writesReg;
        logic useImm;                          // alu operand b from immValue
        logic [`SIMD_DATA_WIDTH-1:0] immValue;
    } decodedInstT;

    typedef struct packed {
        logic [`SIMD_ADDR_WIDTH-1:0] addr;
        logic write;
        logic [`SIMD_DATA_WIDTH-1:0] wdata;
    } memReqT;

endpackage

`default_nettype wire

/* source/simdSettings.svh */
`ifndef SIMD_SETTINGS_SVH
`define SIMD_SETTINGS_SVH

// instruction word, opcode in the top bits
`define SIMD_INSTR_WIDTH 18
`define SIMD_OPCODE_WIDTH 6
`define SIMD_IMM_WIDTH 10

// one 16-bit word holds every lane
`define SIMD_DATA_WIDTH 16

// shared by instruction ROM and data memory
`define SIMD_ADDR_WIDTH 10

// registers in each of the H, O and Q banks
`define SIMD_REG_COUNT 4

`endif

/* testbench/simdCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "simdSettings.svh"

module simdCoreTb import simdPkg::*; ();
    typedef struct packed {
        logic [`SIMD_ADDR_WIDTH-1:0] addr;
        logic [`SIMD_DATA_WIDTH-1:0] data;
    } storeT;

    localparam int memDepth = 1 << `SIMD_ADDR_WIDTH;
    localparam int randomCount = 40;
    // instruction kinds used as index into opBase
    localparam int kAddReg = 0, kAddImm = 1, kSubReg = 2, kSubImm = 3, kMulReg = 4;
    localparam int kMulImm = 5, kAnd = 6, kOr = 7, kNot = 8, kLoad = 9, kStore = 10, kSet = 11;

    logic clk;
    logic rst = 1'b1;
    logic ack = 1'b0;
    logic [`SIMD_DATA_WIDTH-1:0] rdata = '0;
    logic [`SIMD_INSTR_WIDTH-1:0] instr;
    logic [`SIMD_ADDR_WIDTH-1:0] instrAddr;
    logic req;
    memReqT memReq;
    logic done;

    logic [`SIMD_INSTR_WIDTH-1:0] rom [0:memDepth-1];
    logic [`SIMD_DATA_WIDTH-1:0] dataMem [0:memDepth-1];
    logic [`SIMD_DATA_WIDTH-1:0] modelMem [0:memDepth-1];
    logic [`SIMD_DATA_WIDTH-1:0] modelReg [0:2][0:3];
    int opBase [0:11] = '{0, 3, 6, 9, 12, 15, 27, 30, 33, 38, 41, 44};
    storeT expected [$];
    storeT exp;
    int progLen = 0;
    int haltAddr = 0;
    int storeCount = 0;
    int storesSeen = 0;
    int errors = 0;
    int waitLeft = -1;
    int cycle = 0;
    int lastChange = 0;
    logic [`SIMD_ADDR_WIDTH-1:0] lastAddr = '0;
    logic tracked = 1'b0;

    simdCore i_dut (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .ack(ack),
        .rdata(rdata),
        .instrAddr(instrAddr),
        .req(req),
        .memReq(memReq),
        .done(done)
    );

    assign instr = rom[instrAddr];             // combinational rom

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want)
        else
        begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    function automatic logic [15:0] fillWord(input int a);
        logic [31:0] mix;
        mix = a * 40503 + 11293;
        return mix[15:0] ^ mix[25:10];
    endfunction

    // lane count is 1, 2 or 4 for mode 0, 1, 2
    function automatic logic [15:0] laneCalc(input int kind, input logic [15:0] a,
                                              input logic [15:0] b, input int m);
        int w;
        int mask;
        int la;
        int lb;
        int r;
        logic [15:0] res;
        w = 16 >> m;
        mask = (1 << w) - 1;
        res = '0;
        for (int i = 0; i < (1 << m); i++)
        begin
            la = (int'(a) >> (i * w)) & mask;
            lb = (int'(b) >> (i * w)) & mask;
            case (kind)
                kAddReg, kAddImm: r = la + lb;
                kSubReg, kSubImm: r = la - lb;
                kMulReg, kMulImm: r = la * lb;
                kAnd: r = la & lb;
                kOr: r = la | lb;
                default: r = lb;
            endcase
            res = res | 16'((r & mask) << (i * w));
        end
        return res;
    endfunction

    function automatic logic [15:0] replicate(input logic [9:0] imm, input int m);
        int w;
        logic [15:0] res;
        w = 16 >> m;
        res = '0;
        for (int i = 0; i < (1 << m); i++)
            res = res | 16'((int'(imm) & ((1 << w) - 1)) << (i * w));
        return res;
    endfunction

    task automatic modelStep(input logic [17:0] ins);
        int op;
        int kind;
        int m;
        int r0;
        int r2;
        int r3;
        logic [9:0] imm;
        logic [15:0] rep;
        storeT st;
        op = int'(ins[17:12]);
        r0 = int'(ins[11:10]);
        imm = ins[9:0];
        r2 = int'(imm[3:2]);
        r3 = int'(imm[1:0]);
        kind = -1;
        m = 0;
        for (int k = 0; k < 12; k++)
        begin
            if (op >= opBase[k] && op < opBase[k] + 3)
            begin
                kind = k;
                m = op - opBase[k];
            end
        end
        rep = replicate(imm, m);
        case (kind)
            kAddReg, kSubReg, kMulReg, kAnd, kOr:
                modelReg[m][r2] = laneCalc(kind, modelReg[m][r2], modelReg[m][r3], m);
            kAddImm, kSubImm, kMulImm:
                modelReg[m][r0] = laneCalc(kind, modelReg[m][r0], rep, m);
            kNot: modelReg[m][r3] = ~modelReg[m][r3];
            kLoad: modelReg[m][r0] = modelMem[imm];
            kSet: modelReg[m][r0] = rep;
            kStore:
            begin
                st.addr = imm;
                st.data = modelReg[m][r0];
                expected.push_back(st);
                modelMem[imm] = st.data;
            end
            default: ;                         // nop
        endcase
    endtask

    task automatic buildProgram();
        int pc;
        int kind;
        int m;
        logic [11:0] f;
        pc = 0;
        for (int i = 0; i < memDepth; i++)
            rom[i] = {6'd20, 12'd0};           // unused opcode
        while (pc < randomCount)
        begin
            kind = (pc < 6) ? kSet : int'($urandom_range(11, 0));
            m = int'($urandom_range(2, 0));
            f = 12'($urandom);
            rom[pc] = {6'(opBase[kind] + m), f};
            pc++;
            if (kind == kLoad)
            begin
                rom[pc] = {6'(opBase[kStore] + m), f[11:10], 10'($urandom)};  // round trip
                pc++;
            end
        end
        for (int bk = 0; bk < 3; bk++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                rom[pc] = {6'(opBase[kStore] + bk), 2'(r), 10'(960 + bk * 4 + r)};
                pc++;
            end
        end
        rom[pc] = {6'd63, 12'd0};
        haltAddr = pc;
        progLen = pc + 1;
    endtask

    task automatic checkResetOutputs();
        checkValue("req", 32'(req), 0);
        checkValue("done", 32'(done), 0);
        checkValue("instrAddr", 32'(instrAddr), 0);
    endtask

    // data memory with a random delay before raising ack and before dropping it
    always @(posedge clk)
    begin
        if (rst)
        begin
            ack <= 1'b0;
            waitLeft = -1;
        end
        else if (ack)
        begin
            if (!req)
            begin
                if (waitLeft < 0)
                    waitLeft = int'($urandom_range(3, 0));
                if (waitLeft == 0)
                    ack <= 1'b0;               // ack may linger after req drops
                waitLeft = waitLeft - 1;
            end
        end
        else if (req)
        begin
            if (waitLeft < 0)
                waitLeft = int'($urandom_range(5, 0));
            if (waitLeft == 0)
            begin
                if (memReq.write)
                begin
                    storesSeen++;
                    assert (expected.size() != 0)
                    else
                    begin
                        errors++;
                        $display("store to %h not predicted by the model", memReq.addr);
                    end
                    if (expected.size() != 0)
                    begin
                        exp = expected.pop_front();
                        checkValue("memReq.addr", 32'(memReq.addr), 32'(exp.addr));
                        checkValue("memReq.wdata", 32'(memReq.wdata), 32'(exp.data));
                    end
                    dataMem[memReq.addr] = memReq.wdata;
                end
                else
                    rdata <= dataMem[memReq.addr];
                ack <= 1'b1;
            end
            waitLeft = waitLeft - 1;
        end
    end

    // pc steps by one every 5 cycles on non-memory instructions
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (rst)
        begin
            tracked = 1'b0;
            lastAddr = '0;
        end
        else if (instrAddr != lastAddr)
        begin
            checkValue("instrAddr", 32'(instrAddr), 32'(lastAddr + 1'b1));
            if (tracked && !(rom[lastAddr][17:12] >= 6'd38 && rom[lastAddr][17:12] <= 6'd43))
                checkValue("instrAddr spacing", 32'(cycle - lastChange), 5);
            tracked = 1'b1;
            lastAddr = instrAddr;
            lastChange = cycle;
        end
    end

    assert property (@(posedge clk) disable iff (rst) $fell(req) |-> $past(ack))
    else
    begin
        errors++;
        $display("req dropped before ack was raised");
    end

    assert property (@(posedge clk) disable iff (rst) $rose(req) |-> !$past(ack))
    else
    begin
        errors++;
        $display("req raised while ack was still high");
    end

    assert property (@(posedge clk) disable iff (rst) (req && $past(req)) |-> $stable(memReq))
    else
    begin
        errors++;
        $display("memReq changed while req was high");
    end

    assert property (@(posedge clk) disable iff (rst) $past(done) |-> done && $stable(instrAddr))
    else
    begin
        errors++;
        $display("core left the halt state or its pc moved");
    end

    assert property (@(posedge clk) disable iff (rst) done |-> !req)
    else
    begin
        errors++;
        $display("memory request issued after halt");
    end

    initial
    begin
        void'($urandom(32'hd481_9c21));
        buildProgram();
        for (int a = 0; a < memDepth; a++)
        begin
            dataMem[a] = fillWord(a);
            modelMem[a] = fillWord(a);
        end
        for (int bk = 0; bk < 3; bk++)
        begin
            for (int r = 0; r < 4; r++)
                modelReg[bk][r] = '0;
        end
        for (int i = 0; i < haltAddr; i++)
            modelStep(rom[i]);
        storeCount = expected.size();

        for (int c = 1; c <= 16; c++)
        begin
            @(posedge clk);
            if (c == 16)
                rst <= 1'b0;
            @(negedge clk);
            checkResetOutputs();
        end
        @(negedge clk);
        checkResetOutputs();                   // first cycle out of reset

        wait (done === 1'b1);
        repeat (20)
        begin
            @(negedge clk);
            checkValue("done", 32'(done), 1);
            checkValue("instrAddr", 32'(instrAddr), 32'(haltAddr));
        end
        checkValue("pending stores", 32'(expected.size()), 0);
        checkValue("stores seen", 32'(storesSeen), 32'(storeCount));

        $display("errors: %0d, stores checked: %0d of %0d", errors, storesSeen, storeCount);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        @(posedge clk);
        repeat (16 + progLen * 20) @(posedge clk);
        $display("timeout: core did not halt in %0d cycles, errors: %0d",
                 16 + progLen * 20, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
